// File: verilog/arcade_pkg.sv
`default_nettype none

package arcade_pkg;

	localparam int KEY_CODE_W = 8;
	localparam int JOY_W      = 8;
	localparam int STATUS_W   = 32;
	localparam int AUDIO_W    = 10;
	localparam int RESET_HOLD = 16;

	// ps/2 set 2 scan codes
	localparam logic [KEY_CODE_W-1:0] KEY_UP     = 8'h75;
	localparam logic [KEY_CODE_W-1:0] KEY_DOWN   = 8'h72;
	localparam logic [KEY_CODE_W-1:0] KEY_LEFT   = 8'h6B;
	localparam logic [KEY_CODE_W-1:0] KEY_RIGHT  = 8'h74;
	localparam logic [KEY_CODE_W-1:0] KEY_COIN   = 8'h76; // esc
	localparam logic [KEY_CODE_W-1:0] KEY_START1 = 8'h05; // f1
	localparam logic [KEY_CODE_W-1:0] KEY_START2 = 8'h06; // f2
	localparam logic [KEY_CODE_W-1:0] KEY_FIRE1  = 8'h29; // space
	localparam logic [KEY_CODE_W-1:0] KEY_FIRE2  = 8'h11; // alt

	localparam int ST_RESET       = 0;
	localparam int ST_ROTATE      = 2;
	localparam int ST_SCANLINE_LO = 3; // two bits wide
	localparam int ST_BLEND       = 5;
	localparam int ST_RESET2      = 6;

	localparam int JOY_RIGHT = 0;
	localparam int JOY_LEFT  = 1;
	localparam int JOY_DOWN  = 2;
	localparam int JOY_UP    = 3;
	localparam int JOY_FIRE  = 4;
	localparam int JOY_BOMB  = 5;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic coin;
		logic start1;
		logic start2;
		logic fire1;
		logic fire2;
		logic spare; // always zero
	} key_buttons_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic bomb;
	} game_controls_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic       hb;
		logic       vb;
		logic       hs;
		logic       vs;
	} core_video_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic       hs;
		logic       vs;
	} vga_out_t;

endpackage

`default_nettype wire

// File: verilog/key_latch.sv
`default_nettype none

module key_latch import arcade_pkg::*; (
	input  wire logic                  clk_18,
	input  wire logic                  rst_n,
	input  wire logic                  key_strobe,
	input  wire logic                  key_pressed,
	input  wire logic [KEY_CODE_W-1:0] key_code,
	output key_buttons_t               keys
);

	always_ff @(posedge clk_18) begin
		if (!rst_n) begin
			keys <= '0;
		end else if (key_strobe) begin
			case (key_code)
				KEY_UP: begin
					keys.up <= key_pressed;
				end
				KEY_DOWN: begin
					keys.down <= key_pressed;
				end
				KEY_LEFT: begin
					keys.left <= key_pressed;
				end
				KEY_RIGHT: begin
					keys.right <= key_pressed;
				end
				KEY_COIN: begin
					keys.coin <= key_pressed;
				end
				KEY_START1: begin
					keys.start1 <= key_pressed;
				end
				KEY_START2: begin
					keys.start2 <= key_pressed;
				end
				KEY_FIRE1: begin
					keys.fire1 <= key_pressed;
				end
				KEY_FIRE2: begin
					keys.fire2 <= key_pressed;
				end
				default: begin
					keys.spare <= 1'b0; // unknown code leaves levels held
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/control_mux.sv
`default_nettype none

module control_mux import arcade_pkg::*; (
	input  wire logic             clk_18,
	input  wire logic             rst_n,
	input  key_buttons_t          keys,
	input  wire logic [JOY_W-1:0] joystick_0,
	input  wire logic [JOY_W-1:0] joystick_1,
	input  wire logic             rotate,
	output game_controls_t        controls
);

	logic raw_up;
	logic raw_down;
	logic raw_left;
	logic raw_right;
	logic raw_fire;
	logic raw_bomb;

	always_comb begin
		raw_up    = keys.up | joystick_0[JOY_UP] | joystick_1[JOY_UP];
		raw_down  = keys.down | joystick_0[JOY_DOWN] | joystick_1[JOY_DOWN];
		raw_left  = keys.left | joystick_0[JOY_LEFT] | joystick_1[JOY_LEFT];
		raw_right = keys.right | joystick_0[JOY_RIGHT] | joystick_1[JOY_RIGHT];
		raw_fire  = keys.fire1 | joystick_0[JOY_FIRE] | joystick_1[JOY_FIRE];
		raw_bomb  = keys.fire2 | joystick_0[JOY_BOMB] | joystick_1[JOY_BOMB];
	end

	always_ff @(posedge clk_18) begin
		if (!rst_n) begin
			controls <= '0;
		end else begin
			controls.coin   <= keys.coin;
			controls.start1 <= keys.start1;
			controls.start2 <= keys.start2;
			// low rotate means cabinet on its side
			controls.up     <= rotate ? raw_up : raw_left;
			controls.down   <= rotate ? raw_down : raw_right;
			controls.left   <= rotate ? raw_left : raw_down;
			controls.right  <= rotate ? raw_right : raw_up;
			controls.fire   <= raw_fire;
			controls.bomb   <= raw_bomb;
		end
	end

endmodule

`default_nettype wire

// File: verilog/reset_ctrl.sv
`default_nettype none

module reset_ctrl import arcade_pkg::*; (
	input  wire logic                clk_18,
	input  wire logic                rst_n,
	input  wire logic [STATUS_W-1:0] status,
	input  wire logic [1:0]          buttons,
	output logic                     core_reset
);

	localparam int CNT_W = $clog2(RESET_HOLD);

	logic             req_q;
	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk_18) begin
		if (!rst_n) begin
			req_q    <= 1'b0;
			hold_cnt <= CNT_W'(RESET_HOLD - 1);
		end else begin
			req_q <= status[ST_RESET] | status[ST_RESET2] | buttons[1];
			if (req_q) begin
				hold_cnt <= CNT_W'(RESET_HOLD - 1); // reload while requested
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
		end
	end

	// sample itself covers the first held cycle
	assign core_reset = req_q | (hold_cnt != '0);

endmodule

`default_nettype wire

// File: verilog/video_out.sv
`default_nettype none

module video_out import arcade_pkg::*; (
	input  wire logic                clk_18,
	input  wire logic                rst_n,
	input  core_video_t              video,
	input  wire logic [STATUS_W-1:0] status,
	input  wire logic                scandoubler_disable,
	output vga_out_t                 vga
);

	logic       blank;
	logic [2:0] b_ext;
	logic [5:0] wide_r;
	logic [5:0] wide_g;
	logic [5:0] wide_b;
	logic [5:0] prev_r;
	logic [5:0] prev_g;
	logic [5:0] prev_b;
	logic [1:0] dim_level;
	logic       hs_q;
	logic       line_odd;

	// optional blend with previous pixel, then scanline darkening
	function automatic logic [5:0] shade(
		input logic [5:0] cur,
		input logic [5:0] prev,
		input logic       blend,
		input logic [1:0] level
	);
		logic [6:0] sum;
		logic [5:0] px;
		logic [7:0] prod;
		sum  = {1'b0, cur} + {1'b0, prev};
		px   = blend ? sum[6:1] : cur;
		prod = px * level;
		return px - prod[7:2];
	endfunction

	always_comb begin
		blank  = video.hb | video.vb;
		b_ext  = {video.b[0], video.b}; // 2 bits stretched to 3
		wide_r = blank ? 6'd0 : {video.r, video.r};
		wide_g = blank ? 6'd0 : {video.g, video.g};
		wide_b = blank ? 6'd0 : {b_ext, b_ext};
		if (line_odd && !scandoubler_disable) begin
			dim_level = status[ST_SCANLINE_LO +: 2];
		end else begin
			dim_level = 2'd0;
		end
	end

	always_ff @(posedge clk_18) begin
		if (!rst_n) begin
			hs_q     <= 1'b0;
			line_odd <= 1'b0;
		end else begin
			hs_q <= video.hs;
			if (video.vs) begin
				line_odd <= 1'b0;
			end else if (video.hs && !hs_q) begin
				line_odd <= ~line_odd; // hs rising edge
			end
		end
	end

	always_ff @(posedge clk_18) begin
		if (!rst_n) begin
			prev_r <= '0;
			prev_g <= '0;
			prev_b <= '0;
			vga    <= '0;
		end else begin
			prev_r <= wide_r;
			prev_g <= wide_g;
			prev_b <= wide_b;
			vga.r  <= shade(wide_r, prev_r, status[ST_BLEND], dim_level);
			vga.g  <= shade(wide_g, prev_g, status[ST_BLEND], dim_level);
			vga.b  <= shade(wide_b, prev_b, status[ST_BLEND], dim_level);
			vga.hs <= video.hs;
			vga.vs <= video.vs;
		end
	end

endmodule

`default_nettype wire

// File: verilog/sigma_delta_dac.sv
`default_nettype none

module sigma_delta_dac import arcade_pkg::*; (
	input  wire logic               clk_18,
	input  wire logic               rst_n,
	input  wire logic [AUDIO_W-1:0] sample,
	output logic                    bit_out
);

	logic [AUDIO_W-1:0] acc;
	logic [AUDIO_W:0]   sum;

	// carry out is the density-coded output
	assign sum = {1'b0, acc} + {1'b0, sample};

	always_ff @(posedge clk_18) begin
		if (!rst_n) begin
			acc     <= '0;
			bit_out <= 1'b0;
		end else begin
			acc     <= sum[AUDIO_W-1:0];
			bit_out <= sum[AUDIO_W];
		end
	end

endmodule

`default_nettype wire

// File: verilog/arcade_shell.sv
`default_nettype none

module arcade_shell import arcade_pkg::*; (
	input  wire logic                  clk_18,
	input  wire logic                  rst_n,
	input  wire logic                  key_strobe,
	input  wire logic                  key_pressed,
	input  wire logic [KEY_CODE_W-1:0] key_code,
	input  wire logic [JOY_W-1:0]      joystick_0,
	input  wire logic [JOY_W-1:0]      joystick_1,
	input  wire logic [STATUS_W-1:0]   status,
	input  wire logic [1:0]            buttons,
	input  wire logic                  scandoubler_disable,
	input  core_video_t                video,
	input  wire logic [AUDIO_W-1:0]    audio,
	output logic                       core_reset,
	output game_controls_t             controls,
	output vga_out_t                   vga,
	output logic                       audio_l,
	output logic                       audio_r
);

	key_buttons_t keys;
	logic         dac_bit;

	key_latch u_key_latch (
		.clk_18      (clk_18),
		.rst_n       (rst_n),
		.key_strobe  (key_strobe),
		.key_pressed (key_pressed),
		.key_code    (key_code),
		.keys        (keys)
	);

	control_mux u_control_mux (
		.clk_18     (clk_18),
		.rst_n      (rst_n),
		.keys       (keys),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.rotate     (status[ST_ROTATE]),
		.controls   (controls)
	);

	reset_ctrl u_reset_ctrl (
		.clk_18     (clk_18),
		.rst_n      (rst_n),
		.status     (status),
		.buttons    (buttons),
		.core_reset (core_reset)
	);

	video_out u_video_out (
		.clk_18              (clk_18),
		.rst_n               (rst_n),
		.video               (video),
		.status              (status),
		.scandoubler_disable (scandoubler_disable),
		.vga                 (vga)
	);

	sigma_delta_dac u_dac (
		.clk_18  (clk_18),
		.rst_n   (rst_n),
		.sample  (audio),
		.bit_out (dac_bit)
	);

	// mono source on both channels
	assign audio_l = dac_bit;
	assign audio_r = dac_bit;

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_18,
	output logic rst_n
);

	initial begin
		clk_18 = 1'b0;
		forever #(PERIOD / 2) clk_18 = ~clk_18;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_18);
		#(PERIOD / 10) rst_n = 1'b1; // released off the edge like other inputs
	end

endmodule

`default_nettype wire

// File: tests/arcade_shell_tb.sv
`default_nettype none

module arcade_shell_tb import arcade_pkg::*; ();

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;
	localparam int KEY_EVENTS   = 60;
	localparam int MAP_STEPS    = 80;
	localparam int VIDEO_CYCLES = 600;
	localparam int AUDIO_RUNS   = 4;
	localparam int PULSE_LEN [4] = '{1, 2, 5, 30};
	localparam int PULSE_SUM    = PULSE_LEN[0] + PULSE_LEN[1] + PULSE_LEN[2] + PULSE_LEN[3];
	localparam int TEST_CYCLES  = 10 + 2 * KEY_EVENTS + 2 * MAP_STEPS + VIDEO_CYCLES + 1
		+ AUDIO_RUNS * 1026 + 2 * RESET_HOLD + 3 * (PULSE_SUM + 4 * (RESET_HOLD + 5));
	localparam int MARGIN       = 200;
	localparam logic [1:0] SIG_CTRL  = 2'd0;
	localparam logic [1:0] SIG_VGA   = 2'd1;
	localparam logic [1:0] SIG_RESET = 2'd2;
	localparam logic [1:0] SIG_AUDIO = 2'd3;
	localparam logic [KEY_CODE_W-1:0] KNOWN_CODES [9] = '{KEY_UP, KEY_DOWN, KEY_LEFT,
		KEY_RIGHT, KEY_COIN, KEY_START1, KEY_START2, KEY_FIRE1, KEY_FIRE2};

	typedef struct packed {
		int          due;
		logic [1:0]  sig;
		logic [31:0] val;
	} pending_t;

	logic                  clk_18;
	logic                  por_n;
	logic                  soft_rst_n;
	logic                  dut_rst_n;
	logic                  key_strobe;
	logic                  key_pressed;
	logic [KEY_CODE_W-1:0] key_code;
	logic [JOY_W-1:0]      joystick_0;
	logic [JOY_W-1:0]      joystick_1;
	logic [STATUS_W-1:0]   status;
	logic [1:0]            buttons;
	logic                  scandoubler_disable;
	core_video_t           video;
	logic [AUDIO_W-1:0]    audio;
	logic                  core_reset;
	game_controls_t        controls;
	vga_out_t              vga;
	logic                  audio_l;
	logic                  audio_r;
	int                    cycle = 0;
	int                    check_count = 0;
	int                    ones = 0;
	int                    count_from = 0;
	int                    count_to = -1;
	pending_t              pending_q[$];
	key_buttons_t          key_model;

	tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) u_clock (
		.clk_18 (clk_18),
		.rst_n  (por_n)
	);

	assign dut_rst_n = por_n & soft_rst_n; // soft reset for the audio runs

	arcade_shell dut (
		.clk_18              (clk_18),
		.rst_n               (dut_rst_n),
		.key_strobe          (key_strobe),
		.key_pressed         (key_pressed),
		.key_code            (key_code),
		.joystick_0          (joystick_0),
		.joystick_1          (joystick_1),
		.status              (status),
		.buttons             (buttons),
		.scandoubler_disable (scandoubler_disable),
		.video               (video),
		.audio               (audio),
		.core_reset          (core_reset),
		.controls            (controls),
		.vga                 (vga),
		.audio_l             (audio_l),
		.audio_r             (audio_r)
	);

	function automatic key_buttons_t update_keys(key_buttons_t k, logic [7:0] code,
		logic pressed);
		key_buttons_t n;
		n = k;
		case (code)
			KEY_UP:     n.up = pressed;
			KEY_DOWN:   n.down = pressed;
			KEY_LEFT:   n.left = pressed;
			KEY_RIGHT:  n.right = pressed;
			KEY_COIN:   n.coin = pressed;
			KEY_START1: n.start1 = pressed;
			KEY_START2: n.start2 = pressed;
			KEY_FIRE1:  n.fire1 = pressed;
			KEY_FIRE2:  n.fire2 = pressed;
			default:    n.spare = 1'b0;
		endcase
		return n;
	endfunction

	function automatic game_controls_t map_controls(key_buttons_t k, logic [7:0] j0,
		logic [7:0] j1, logic rotate);
		game_controls_t c;
		logic [7:0]     j;
		logic           u;
		logic           d;
		logic           l;
		logic           r;
		j = j0 | j1;
		u = k.up | j[JOY_UP];
		d = k.down | j[JOY_DOWN];
		l = k.left | j[JOY_LEFT];
		r = k.right | j[JOY_RIGHT];
		c.coin = k.coin;
		c.start1 = k.start1;
		c.start2 = k.start2;
		c.up = rotate ? u : l; // sideways cabinet when low
		c.down = rotate ? d : r;
		c.left = rotate ? l : d;
		c.right = rotate ? r : u;
		c.fire = k.fire1 | j[JOY_FIRE];
		c.bomb = k.fire2 | j[JOY_BOMB];
		return c;
	endfunction

	function automatic logic [17:0] widen(core_video_t v);
		if (v.hb || v.vb) return 18'd0;
		return {v.r, v.r, v.g, v.g, v.b[0], v.b, v.b[0], v.b};
	endfunction

	function automatic logic [5:0] pixel_ref(logic [5:0] cur, logic [5:0] prev, logic blend,
		logic [1:0] k);
		int px;
		px = blend ? (int'(cur) + int'(prev)) / 2 : int'(cur);
		return 6'(px - (px * int'(k)) / 4);
	endfunction

	function automatic vga_out_t video_ref(logic [17:0] cur, logic [17:0] prev, core_video_t v,
		logic blend, logic [1:0] k);
		vga_out_t o;
		o.r = pixel_ref(cur[17:12], prev[17:12], blend, k);
		o.g = pixel_ref(cur[11:6], prev[11:6], blend, k);
		o.b = pixel_ref(cur[5:0], prev[5:0], blend, k);
		o.hs = v.hs;
		o.vs = v.vs;
		return o;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		check_count++;
		if (got !== want) begin
			fail_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
				$time, name, got, want));
		end
	endtask

	task automatic schedule_check(input int due, input logic [1:0] sig, input logic [31:0] val);
		pending_t p;
		p.due = due;
		p.sig = sig;
		p.val = val;
		pending_q.push_back(p);
	endtask

	task automatic next_cycle();
		@(posedge clk_18);
		#DRIVE_DELAY;
	endtask

	task automatic key_events_test();
		logic [7:0] code;
		logic       pressed;
		for (int i = 0; i < KEY_EVENTS; i++) begin
			if (i < 18) begin
				code = KNOWN_CODES[i % 9]; // every key made and then broken
				pressed = (i < 9);
			end else if ($urandom_range(3, 0) != 0) begin
				code = KNOWN_CODES[$urandom_range(8, 0)];
				pressed = 1'($urandom);
			end else begin
				code = 8'($urandom); // mostly unknown codes
				pressed = 1'($urandom);
			end
			key_strobe = 1'b1;
			key_code = code;
			key_pressed = pressed;
			key_model = update_keys(key_model, code, key_pressed);
			schedule_check(cycle + 2, SIG_CTRL, 32'(map_controls(key_model, '0, '0, 1'b1)));
			next_cycle();
			key_strobe = 1'b0;
			next_cycle();
		end
	endtask

	task automatic mapping_test();
		game_controls_t want;
		for (int i = 0; i < MAP_STEPS; i++) begin
			key_strobe = 1'b1;
			key_code = KNOWN_CODES[$urandom_range(8, 0)];
			key_pressed = 1'($urandom);
			key_model = update_keys(key_model, key_code, key_pressed);
			next_cycle();
			key_strobe = 1'b0;
			joystick_0 = 8'($urandom);
			joystick_1 = 8'($urandom);
			status[ST_ROTATE] = 1'($urandom);
			want = map_controls(key_model, joystick_0, joystick_1, status[ST_ROTATE]);
			schedule_check(cycle + 1, SIG_CTRL, 32'(want));
			next_cycle();
		end
		joystick_0 = '0;
		joystick_1 = '0;
		status[ST_ROTATE] = 1'b1;
	endtask

	task automatic video_test();
		core_video_t v;
		logic [17:0] cur;
		logic [17:0] prev;
		logic        odd;
		logic        hs_prev;
		logic [1:0]  k;
		prev = '0;
		odd = 1'b0;
		hs_prev = 1'b0;
		for (int i = 0; i < VIDEO_CYCLES; i++) begin
			v = core_video_t'(12'($urandom));
			v.hb = ($urandom_range(3, 0) == 0);
			v.vb = ($urandom_range(15, 0) == 0);
			v.hs = ($urandom_range(3, 0) == 0);
			v.vs = ($urandom_range(63, 0) == 0);
			status[ST_SCANLINE_LO +: 2] = 2'($urandom);
			status[ST_BLEND] = 1'($urandom);
			scandoubler_disable = ($urandom_range(3, 0) == 0);
			video = v;
			cur = widen(v);
			k = (odd && !scandoubler_disable) ? status[ST_SCANLINE_LO +: 2] : 2'd0;
			schedule_check(cycle + 1, SIG_VGA, 32'(video_ref(cur, prev, v, status[ST_BLEND], k)));
			prev = cur;
			if (v.vs) begin
				odd = 1'b0;
			end else if (v.hs && !hs_prev) begin
				odd = !odd; // new line on hs rising edge
			end
			hs_prev = v.hs;
			next_cycle();
		end
		video = '0;
		status[ST_SCANLINE_LO +: 2] = 2'd0;
		status[ST_BLEND] = 1'b0;
		scandoubler_disable = 1'b0;
		next_cycle();
	endtask

	task automatic audio_test();
		for (int i = 0; i < AUDIO_RUNS; i++) begin
			audio = 10'($urandom);
			soft_rst_n = 1'b0;
			key_model = '0;
			next_cycle();
			soft_rst_n = 1'b1;
			count_from = cycle + 1; // first accumulating edge
			count_to = cycle + 1024;
			schedule_check(count_to, SIG_AUDIO, 32'(audio));
			repeat (1024) next_cycle();
		end
	endtask

	task automatic reset_test();
		int len;
		int waited;
		waited = 0;
		while (core_reset && waited < 2 * RESET_HOLD) begin
			next_cycle();
			waited++;
		end
		if (core_reset) fail_run("core_reset stayed high after the audio runs");
		for (int src = 0; src < 3; src++) begin
			for (int p = 0; p < 4; p++) begin
				len = PULSE_LEN[p];
				for (int j = 0; j < len + RESET_HOLD + 5; j++) begin
					status[ST_RESET] = (src == 0) && (j < len);
					status[ST_RESET2] = (src == 1) && (j < len);
					buttons[1] = (src == 2) && (j < len);
					schedule_check(cycle, SIG_RESET, 32'((j >= 1) && (j < len + RESET_HOLD)));
					next_cycle();
				end
			end
		end
	endtask

	always @(posedge clk_18) begin
		cycle <= cycle + 1;
	end

	// outputs compared mid-cycle away from both edges
	always @(negedge clk_18) begin
		pending_t p;
		if (cycle == count_from) ones = 0;
		if (cycle >= count_from && cycle <= count_to && audio_l) ones++;
		if (cycle > 0) check("audio_r", 32'(audio_r), 32'(audio_l));
		if (pending_q.size() > 0 && pending_q[0].due < cycle) begin
			fail_run("an expected value was not compared in its cycle");
		end
		while (pending_q.size() > 0 && pending_q[0].due == cycle) begin
			p = pending_q.pop_front();
			case (p.sig)
				SIG_CTRL:  check("controls", 32'(controls), p.val);
				SIG_VGA:   check("vga", 32'(vga), p.val);
				SIG_RESET: check("core_reset", 32'(core_reset), p.val);
				default:   check("audio_l high count", 32'(ones), p.val);
			endcase
		end
	end

	initial begin
		#((TEST_CYCLES + MARGIN) * CLK_PERIOD);
		fail_run($sformatf("timeout: run did not finish within %0d cycles",
			TEST_CYCLES + MARGIN));
	end

	initial begin
		void'($urandom(34));
		soft_rst_n = 1'b1;
		key_strobe = 1'b0;
		key_pressed = 1'b0;
		key_code = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		status = '0;
		status[ST_ROTATE] = 1'b1;
		buttons = '0;
		scandoubler_disable = 1'b0;
		video = '0;
		audio = '0;
		key_model = '0;
		wait (por_n === 1'b1);
		next_cycle();
		key_events_test();
		mapping_test();
		video_test();
		audio_test();
		reset_test();
		next_cycle();
		next_cycle();
		if (pending_q.size() == 0 && check_count > 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			fail_run("expected values were left unchecked or no check ran");
		end
	end

endmodule

`default_nettype wire

// File: sources.f
verilog/arcade_pkg.sv
verilog/key_latch.sv
verilog/control_mux.sv
verilog/reset_ctrl.sv
verilog/video_out.sv
verilog/sigma_delta_dac.sv
verilog/arcade_shell.sv
tests/tb_clock.sv
tests/arcade_shell_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the arcade shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=arcade_shell_sim

verilator --binary --timing -f sources.f --top-module arcade_shell_tb -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
